//--- rtl/core_pkg.sv
package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:2] pc_t;      // Word address, byte offset dropped
   typedef logic [4:0]  reg_idx_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_IMM,
      WB_PC4
   } wb_sel_e;

   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LT,
      BR_GE,
      BR_JAL,
      BR_JALR
   } branch_op_e;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;

   localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- rtl/instruction_fetch_stage.sv
`timescale 1ns/1ps

module instruction_fetch_stage import core_pkg::*; #(
   parameter pc_t RESET_PC = '0
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  logic  stall_i,
   input  logic  branch_taken_i,
   input  pc_t   branch_target_i,
   input  logic  imem_ready_i,
   input  word_t imem_rdata_i,
   output logic  imem_valid_o,
   output pc_t   imem_addr_o,
   output word_t instr_o,
   output pc_t   pc_o,
   output logic  instr_valid_o
);

   pc_t  pc_q;
   logic run_q;
   logic fetch_done;

   // Request dropped in a redirect cycle so the address only moves while idle
   assign imem_valid_o = run_q && !branch_taken_i;
   assign imem_addr_o  = pc_q;
   assign fetch_done   = imem_valid_o && imem_ready_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         run_q <= 1'b0;
         pc_q  <= RESET_PC;
      end else begin
         run_q <= 1'b1;
         if (branch_taken_i) begin
            pc_q <= branch_target_i;
         end else if (fetch_done && !stall_i) begin
            pc_q <= pc_q + 30'd1;
         end
      end
   end

   // IF/ID register
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         instr_o       <= NOP_INSTR;
         instr_valid_o <= 1'b0;
      end else if (branch_taken_i || (!stall_i && !fetch_done)) begin
         instr_o       <= NOP_INSTR;  // Flush or no word this cycle
         instr_valid_o <= 1'b0;
      end else if (!stall_i) begin
         instr_o       <= imem_rdata_i;
         instr_valid_o <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_done && !stall_i) begin
         pc_o <= pc_q;
      end
   end

endmodule

//--- rtl/instruction_decode_stage.sv
`timescale 1ns/1ps

module instruction_decode_stage import core_pkg::*; (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  word_t      instr_i,
   input  pc_t        pc_i,
   input  logic       instr_valid_i,
   input  logic       flush_i,
   input  logic       hold_i,
   input  logic       wb_en_i,
   input  reg_idx_t   wb_rd_i,
   input  word_t      wb_data_i,
   output logic       load_stall_o,
   output word_t      rs1_value_o,
   output word_t      rs2_value_o,
   output reg_idx_t   rs1_label_o,
   output reg_idx_t   rs2_label_o,
   output word_t      imm_o,
   output reg_idx_t   rd_o,
   output alu_op_e    alu_op_o,
   output logic       op1_pc_sel_o,
   output logic       op2_imm_sel_o,
   output wb_sel_e    wb_sel_o,
   output branch_op_e branch_op_o,
   output logic       is_load_o,
   output logic       is_store_o,
   output logic       reg_write_o,
   output pc_t        pc_o
);

   word_t      regs [1:31];  // x0 is not stored
   logic [6:0] opcode;
   logic [2:0] funct3;
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   reg_idx_t   rd;
   word_t      rs1_data;
   word_t      rs2_data;
   word_t      imm;
   alu_op_e    funct_op;
   alu_op_e    alu_op;
   wb_sel_e    wb_sel;
   branch_op_e branch_op;
   logic       op1_pc_sel;
   logic       op2_imm_sel;
   logic       is_load;
   logic       is_store;
   logic       reg_write;

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign rd     = instr_i[11:7];
   assign rs1    = instr_i[19:15];
   assign rs2    = instr_i[24:20];

   always_comb begin
      case (funct3)
         3'b000:  funct_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
         3'b001:  funct_op = ALU_SLL;
         3'b010:  funct_op = ALU_SLT;
         3'b011:  funct_op = ALU_SLTU;
         3'b100:  funct_op = ALU_XOR;
         3'b101:  funct_op = instr_i[30] ? ALU_SRA : ALU_SRL;
         3'b110:  funct_op = ALU_OR;
         default: funct_op = ALU_AND;
      endcase
   end

   always_comb begin
      alu_op      = ALU_ADD;
      op1_pc_sel  = 1'b0;
      op2_imm_sel = 1'b1;
      wb_sel      = WB_ALU;
      branch_op   = BR_NONE;
      is_load     = 1'b0;
      is_store    = 1'b0;
      reg_write   = 1'b1;
      imm         = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type by default
      case (opcode)
         OPC_OP: begin
            alu_op      = funct_op;
            op2_imm_sel = 1'b0;
         end
         OPC_OP_IMM: alu_op = funct_op;
         OPC_LUI: begin
            imm    = {instr_i[31:12], 12'b0};
            wb_sel = WB_IMM;
         end
         OPC_AUIPC: begin
            imm        = {instr_i[31:12], 12'b0};
            op1_pc_sel = 1'b1;
         end
         OPC_LOAD: begin
            is_load = 1'b1;
            wb_sel  = WB_LOAD;
         end
         OPC_STORE: begin
            imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            is_store  = 1'b1;
            reg_write = 1'b0;
         end
         OPC_BRANCH: begin
            imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
            reg_write = 1'b0;
            case (funct3)
               3'b000:  branch_op = BR_EQ;
               3'b001:  branch_op = BR_NE;
               3'b100:  branch_op = BR_LT;
               3'b101:  branch_op = BR_GE;
               default: branch_op = BR_NONE;
            endcase
         end
         OPC_JAL: begin
            imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};
            branch_op = BR_JAL;
            wb_sel    = WB_PC4;
         end
         OPC_JALR: begin
            branch_op = BR_JALR;
            wb_sel    = WB_PC4;
         end
         default: reg_write = 1'b0;  // Unsupported opcode acts as a NOP
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (wb_en_i && wb_rd_i != '0) begin
         regs[wb_rd_i] <= wb_data_i;
      end
   end

   // Same-cycle write is passed straight to the read
   function automatic word_t read_reg(reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wb_en_i && wb_rd_i == idx) begin
         return wb_data_i;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs1_data = read_reg(rs1);
      rs2_data = read_reg(rs2);
   end

   // Load in EX feeding the instruction in ID
   assign load_stall_o = instr_valid_i && is_load_o && rd_o != '0 &&
                         (rd_o == rs1 || rd_o == rs2);

   // ID/EX register
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reg_write_o <= 1'b0;
         is_load_o   <= 1'b0;
         is_store_o  <= 1'b0;
         branch_op_o <= BR_NONE;
         rd_o        <= '0;
      end else if (!hold_i) begin
         if (flush_i || load_stall_o) begin
            reg_write_o <= 1'b0;  // Bubble
            is_load_o   <= 1'b0;
            is_store_o  <= 1'b0;
            branch_op_o <= BR_NONE;
            rd_o        <= '0;
         end else begin
            reg_write_o <= instr_valid_i && reg_write && rd != '0;
            is_load_o   <= instr_valid_i && is_load;
            is_store_o  <= instr_valid_i && is_store;
            branch_op_o <= instr_valid_i ? branch_op : BR_NONE;
            rd_o        <= rd;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!hold_i) begin
         rs1_value_o   <= rs1_data;
         rs2_value_o   <= rs2_data;
         rs1_label_o   <= rs1;
         rs2_label_o   <= rs2;
         imm_o         <= imm;
         alu_op_o      <= alu_op;
         op1_pc_sel_o  <= op1_pc_sel;
         op2_imm_sel_o <= op2_imm_sel;
         wb_sel_o      <= wb_sel;
         pc_o          <= pc_i;
      end
   end

endmodule

//--- rtl/instruction_execution_stage.sv
`timescale 1ns/1ps

module instruction_execution_stage import core_pkg::*; (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       hold_i,
   input  word_t      rs1_value_i,
   input  word_t      rs2_value_i,
   input  reg_idx_t   rs1_label_i,
   input  reg_idx_t   rs2_label_i,
   input  word_t      imm_i,
   input  reg_idx_t   rd_i,
   input  alu_op_e    alu_op_i,
   input  logic       op1_pc_sel_i,
   input  logic       op2_imm_sel_i,
   input  wb_sel_e    wb_sel_i,
   input  branch_op_e branch_op_i,
   input  logic       is_load_i,
   input  logic       is_store_i,
   input  logic       reg_write_i,
   input  pc_t        pc_i,
   input  reg_idx_t   mem_rd_i,
   input  logic       mem_reg_write_i,
   input  word_t      mem_alu_out_i,
   input  reg_idx_t   wb_rd_i,
   input  logic       wb_en_i,
   input  word_t      wb_data_i,
   output logic       branch_taken_o,
   output pc_t        branch_target_o,
   output word_t      alu_out_o,
   output word_t      rs2_fwd_o,
   output reg_idx_t   rd_o,
   output wb_sel_e    wb_sel_o,
   output word_t      imm_o,
   output pc_t        pc_o,
   output logic       is_load_o,
   output logic       is_store_o,
   output logic       reg_write_o
);

   word_t rs1_fwd;
   word_t rs2_fwd;
   word_t mem_fwd;
   word_t op_a;
   word_t op_b;
   word_t alu_res;
   word_t target_sum;
   logic  taken_now;
   logic  taken_q;

   // LUI result travels in imm rather than alu_out
   assign mem_fwd = (wb_sel_o == WB_IMM) ? imm_o : mem_alu_out_i;

   function automatic word_t forward(reg_idx_t label, word_t value);
      if (label == '0) begin
         return value;
      end
      if (mem_reg_write_i && mem_rd_i == label) begin
         return mem_fwd;  // Youngest producer first
      end
      if (wb_en_i && wb_rd_i == label) begin
         return wb_data_i;
      end
      return value;
   endfunction

   always_comb begin
      rs1_fwd = forward(rs1_label_i, rs1_value_i);
      rs2_fwd = forward(rs2_label_i, rs2_value_i);
   end

   assign op_a = op1_pc_sel_i ? {pc_i, 2'b00} : rs1_fwd;
   assign op_b = op2_imm_sel_i ? imm_i : rs2_fwd;

   always_comb begin
      case (alu_op_i)
         ALU_SUB:  alu_res = op_a - op_b;
         ALU_AND:  alu_res = op_a & op_b;
         ALU_OR:   alu_res = op_a | op_b;
         ALU_XOR:  alu_res = op_a ^ op_b;
         ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: alu_res = {31'b0, op_a < op_b};
         ALU_SLL:  alu_res = op_a << op_b[4:0];
         ALU_SRL:  alu_res = op_a >> op_b[4:0];
         ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
         default:  alu_res = op_a + op_b;
      endcase
   end

   always_comb begin
      case (branch_op_i)
         BR_EQ:   taken_now = (rs1_fwd == rs2_fwd);
         BR_NE:   taken_now = (rs1_fwd != rs2_fwd);
         BR_LT:   taken_now = ($signed(rs1_fwd) < $signed(rs2_fwd));
         BR_GE:   taken_now = ($signed(rs1_fwd) >= $signed(rs2_fwd));
         BR_JAL,
         BR_JALR: taken_now = 1'b1;
         default: taken_now = 1'b0;
      endcase
   end

   // Bit 0 of a JALR target falls away with the word address
   assign target_sum      = ((branch_op_i == BR_JALR) ? rs1_fwd : {pc_i, 2'b00}) + imm_i;
   assign branch_target_o = target_sum[31:2];

   // Redirect kept up across a data stall
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         taken_q <= 1'b0;
      end else begin
         taken_q <= hold_i && branch_taken_o;
      end
   end

   assign branch_taken_o = taken_now || taken_q;

   // EX/MEM register
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         reg_write_o <= 1'b0;
         is_load_o   <= 1'b0;
         is_store_o  <= 1'b0;
         rd_o        <= '0;
         wb_sel_o    <= WB_ALU;
      end else if (!hold_i) begin
         reg_write_o <= reg_write_i;
         is_load_o   <= is_load_i;
         is_store_o  <= is_store_i;
         rd_o        <= rd_i;
         wb_sel_o    <= wb_sel_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!hold_i) begin
         alu_out_o <= alu_res;
         rs2_fwd_o <= rs2_fwd;  // Store data
         imm_o     <= imm_i;
         pc_o      <= pc_i;
      end
   end

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  word_t    alu_out_i,
   input  word_t    rs2_i,
   input  reg_idx_t rd_i,
   input  wb_sel_e  wb_sel_i,
   input  word_t    imm_i,
   input  pc_t      pc_i,
   input  logic     is_load_i,
   input  logic     is_store_i,
   input  logic     reg_write_i,
   input  logic     dmem_ready_i,
   input  word_t    dmem_rdata_i,
   output logic     dmem_valid_o,
   output logic     dmem_we_o,
   output pc_t      dmem_addr_o,
   output word_t    dmem_wdata_o,
   output logic     wb_en_o,
   output reg_idx_t wb_rd_o,
   output word_t    alu_out_o,
   output word_t    load_val_o,
   output word_t    imm_o,
   output pc_t      pc_o,
   output wb_sel_e  wb_sel_o
);

   logic waiting;

   // Request fields come straight from EX/MEM, which holds while waiting
   assign dmem_valid_o = is_load_i || is_store_i;
   assign dmem_we_o    = is_store_i;
   assign dmem_addr_o  = alu_out_i[31:2];
   assign dmem_wdata_o = rs2_i;

   assign waiting = dmem_valid_o && !dmem_ready_i;

   // MEM/WB register
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_en_o  <= 1'b0;
         wb_rd_o  <= '0;
         wb_sel_o <= WB_ALU;
      end else if (!waiting) begin
         wb_en_o  <= reg_write_i;
         wb_rd_o  <= rd_i;
         wb_sel_o <= wb_sel_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!waiting) begin
         alu_out_o  <= alu_out_i;
         load_val_o <= dmem_rdata_i;  // Taken in the ready cycle
         imm_o      <= imm_i;
         pc_o       <= pc_i;
      end
   end

endmodule

//--- rtl/core.sv
`timescale 1ns/1ps

module core import core_pkg::*; #(
   parameter pc_t RESET_PC = '0
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   output logic  imem_valid_o,
   output pc_t   imem_addr_o,
   input  logic  imem_ready_i,
   input  word_t imem_rdata_i,
   output logic  dmem_valid_o,
   output logic  dmem_we_o,
   output pc_t   dmem_addr_o,
   output word_t dmem_wdata_o,
   input  logic  dmem_ready_i,
   input  word_t dmem_rdata_i
);

   // IF/ID
   word_t      if_instr;
   pc_t        if_pc;
   logic       if_valid;
   // ID/EX
   word_t      id_rs1_value;
   word_t      id_rs2_value;
   reg_idx_t   id_rs1_label;
   reg_idx_t   id_rs2_label;
   word_t      id_imm;
   reg_idx_t   id_rd;
   alu_op_e    id_alu_op;
   logic       id_op1_pc_sel;
   logic       id_op2_imm_sel;
   wb_sel_e    id_wb_sel;
   branch_op_e id_branch_op;
   logic       id_is_load;
   logic       id_is_store;
   logic       id_reg_write;
   pc_t        id_pc;
   // EX/MEM
   word_t      ex_alu_out;
   word_t      ex_rs2;
   reg_idx_t   ex_rd;
   wb_sel_e    ex_wb_sel;
   word_t      ex_imm;
   pc_t        ex_pc;
   logic       ex_is_load;
   logic       ex_is_store;
   logic       ex_reg_write;
   // MEM/WB
   logic       wb_en;
   reg_idx_t   wb_rd;
   word_t      wb_alu_out;
   word_t      wb_load_val;
   word_t      wb_imm;
   pc_t        wb_pc;
   wb_sel_e    wb_sel;
   word_t      wb_data;

   logic       branch_taken;
   pc_t        branch_target;
   logic       load_stall;
   logic       mem_stall;
   logic       if_stall;

   assign mem_stall = dmem_valid_o && !dmem_ready_i;  // Freezes every stage
   assign if_stall  = load_stall || mem_stall;

   instruction_fetch_stage #(
      .RESET_PC(RESET_PC)
   ) u_if (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .stall_i(if_stall),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .imem_ready_i(imem_ready_i), .imem_rdata_i(imem_rdata_i),
      .imem_valid_o(imem_valid_o), .imem_addr_o(imem_addr_o),
      .instr_o(if_instr), .pc_o(if_pc), .instr_valid_o(if_valid)
   );

   instruction_decode_stage u_id (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .instr_i(if_instr), .pc_i(if_pc), .instr_valid_i(if_valid),
      .flush_i(branch_taken), .hold_i(mem_stall),
      .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
      .load_stall_o(load_stall),
      .rs1_value_o(id_rs1_value), .rs2_value_o(id_rs2_value),
      .rs1_label_o(id_rs1_label), .rs2_label_o(id_rs2_label),
      .imm_o(id_imm), .rd_o(id_rd), .alu_op_o(id_alu_op),
      .op1_pc_sel_o(id_op1_pc_sel), .op2_imm_sel_o(id_op2_imm_sel),
      .wb_sel_o(id_wb_sel), .branch_op_o(id_branch_op),
      .is_load_o(id_is_load), .is_store_o(id_is_store),
      .reg_write_o(id_reg_write), .pc_o(id_pc)
   );

   instruction_execution_stage u_ex (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .hold_i(mem_stall),
      .rs1_value_i(id_rs1_value), .rs2_value_i(id_rs2_value),
      .rs1_label_i(id_rs1_label), .rs2_label_i(id_rs2_label),
      .imm_i(id_imm), .rd_i(id_rd), .alu_op_i(id_alu_op),
      .op1_pc_sel_i(id_op1_pc_sel), .op2_imm_sel_i(id_op2_imm_sel),
      .wb_sel_i(id_wb_sel), .branch_op_i(id_branch_op),
      .is_load_i(id_is_load), .is_store_i(id_is_store),
      .reg_write_i(id_reg_write), .pc_i(id_pc),
      .mem_rd_i(ex_rd), .mem_reg_write_i(ex_reg_write), .mem_alu_out_i(ex_alu_out),
      .wb_rd_i(wb_rd), .wb_en_i(wb_en), .wb_data_i(wb_data),
      .branch_taken_o(branch_taken), .branch_target_o(branch_target),
      .alu_out_o(ex_alu_out), .rs2_fwd_o(ex_rs2), .rd_o(ex_rd),
      .wb_sel_o(ex_wb_sel), .imm_o(ex_imm), .pc_o(ex_pc),
      .is_load_o(ex_is_load), .is_store_o(ex_is_store), .reg_write_o(ex_reg_write)
   );

   memory_stage u_mem (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .alu_out_i(ex_alu_out), .rs2_i(ex_rs2), .rd_i(ex_rd), .wb_sel_i(ex_wb_sel),
      .imm_i(ex_imm), .pc_i(ex_pc), .is_load_i(ex_is_load), .is_store_i(ex_is_store),
      .reg_write_i(ex_reg_write),
      .dmem_ready_i(dmem_ready_i), .dmem_rdata_i(dmem_rdata_i),
      .dmem_valid_o(dmem_valid_o), .dmem_we_o(dmem_we_o),
      .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
      .wb_en_o(wb_en), .wb_rd_o(wb_rd), .alu_out_o(wb_alu_out),
      .load_val_o(wb_load_val), .imm_o(wb_imm), .pc_o(wb_pc), .wb_sel_o(wb_sel)
   );

   // Writeback select
   always_comb begin
      case (wb_sel)
         WB_LOAD: wb_data = wb_load_val;
         WB_IMM:  wb_data = wb_imm;
         WB_PC4:  wb_data = {wb_pc + 30'd1, 2'b00};  // Link value is PC+4
         default: wb_data = wb_alu_out;
      endcase
   end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 4,  // 8 ns clock
   parameter int RESET_CYCLES   = 2
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Reset drops away on a falling edge, clear of the sampling edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

//--- tests/core_properties.sv
`timescale 1ns/1ps

module core_properties import core_pkg::*; #(
   parameter pc_t RESET_PC = '0
) (
   input logic  clk_i,
   input logic  arst_n_i,
   input logic  imem_valid_i,
   input pc_t   imem_addr_i,
   input logic  imem_ready_i,
   input logic  dmem_valid_i,
   input logic  dmem_we_i,
   input pc_t   dmem_addr_i,
   input word_t dmem_wdata_i,
   input logic  dmem_ready_i
);

   int unsigned assert_fails = 0;  // Read by the testbench summary
   logic        fetch_seen;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fetch_seen <= 1'b0;
      end else if (imem_valid_i) begin
         fetch_seen <= 1'b1;
      end
   end

   // Nothing can reach the data port before the first fetch
   a_quiet_dmem: assert property (@(posedge clk_i) !fetch_seen |-> !dmem_valid_i)
      else begin
         assert_fails++;
         $error("data request seen before the first instruction fetch");
      end

   a_first_fetch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      imem_valid_i && !fetch_seen |-> imem_addr_i == RESET_PC)
      else begin
         assert_fails++;
         $error("first instruction request is not at the reset PC");
      end

   // A redirect may withdraw the request, otherwise the address holds
   a_imem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      imem_valid_i && !imem_ready_i |=> !imem_valid_i || $stable(imem_addr_i))
      else begin
         assert_fails++;
         $error("instruction address moved while waiting for ready");
      end

   a_dmem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dmem_valid_i && !dmem_ready_i |=> dmem_valid_i && $stable(dmem_addr_i) &&
      $stable(dmem_we_i) && $stable(dmem_wdata_i))
      else begin
         assert_fails++;
         $error("data request dropped or changed while waiting for ready");
      end

endmodule

//--- tests/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

   localparam pc_t         RESET_PC   = 30'h0000_0040;
   localparam word_t       PC_BASE    = {RESET_PC, 2'b00};  // Byte address of word 0
   localparam word_t       DONE_ADDR  = 32'h0000_00FC;
   // About 70 fetches and 20 data accesses, each at worst a few dozen cycles
   localparam int unsigned MAX_CYCLES = 4000;

   logic  clk;
   logic  arst_n;
   logic  imem_valid;
   pc_t   imem_addr;
   logic  imem_ready = 1'b0;
   word_t imem_rdata = NOP_INSTR;
   logic  dmem_valid;
   logic  dmem_we;
   pc_t   dmem_addr;
   word_t dmem_wdata;
   logic  dmem_ready = 1'b0;
   word_t dmem_rdata = '0;

   word_t       prog [$];
   word_t       exp_addr [$];
   word_t       exp_data [$];
   word_t       dmem [0:63];
   logic [31:0] lfsr = 32'hbc477474;
   logic [5:0]  d_idx;
   int unsigned cycles = 0;
   int unsigned errors = 0;
   bit          done = 1'b0;

   tb_clock_gen u_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

   core #(
      .RESET_PC(RESET_PC)
   ) u_core (
      .clk_i(clk), .arst_n_i(arst_n),
      .imem_valid_o(imem_valid), .imem_addr_o(imem_addr),
      .imem_ready_i(imem_ready), .imem_rdata_i(imem_rdata),
      .dmem_valid_o(dmem_valid), .dmem_we_o(dmem_we),
      .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
      .dmem_ready_i(dmem_ready), .dmem_rdata_i(dmem_rdata)
   );

   bind core core_properties #(.RESET_PC(RESET_PC)) u_props (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .imem_valid_i(imem_valid_o), .imem_addr_i(imem_addr_o), .imem_ready_i(imem_ready_i),
      .dmem_valid_i(dmem_valid_o), .dmem_we_i(dmem_we_o), .dmem_addr_i(dmem_addr_o),
      .dmem_wdata_i(dmem_wdata_o), .dmem_ready_i(dmem_ready_i)
   );

   // RV32I instruction formats
   function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
   endfunction

   function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
   endfunction

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic word_t fetch_word(pc_t addr);
      word_t idx;
      idx = {2'b00, addr - RESET_PC};
      if (idx < word_t'(prog.size())) begin
         return prog[idx];
      end
      return NOP_INSTR;
   endfunction

   task automatic expect_store(word_t addr, word_t data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   task automatic check_store(pc_t addr, word_t data);
      word_t ea;
      word_t ed;
      if (exp_addr.size() == 0) begin
         errors++;
         $display("unexpected store of %h to address %h at %0t", data, {addr, 2'b00}, $time);
      end else begin
         ea = exp_addr.pop_front();
         ed = exp_data.pop_front();
         assert ({addr, 2'b00} == ea) else begin
            errors++;
            $display("mismatch at %0t: dmem_addr_o got %h expected %h", $time,
                     {addr, 2'b00}, ea);
         end
         assert (data == ed) else begin
            errors++;
            $display("mismatch at %0t: dmem_wdata_o got %h expected %h", $time, data, ed);
         end
      end
      if ({addr, 2'b00} == DONE_ADDR) begin
         done = 1'b1;
      end
   endtask

   task automatic load_program();
      prog.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));     // x1 = 5
      prog.push_back(i_type(12'hFFD, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));   // x2 = -3
      prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));           // add
      prog.push_back(s_type(12'd0, 5'd3, 5'd0));
      prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));           // sub
      prog.push_back(r_type(7'h00, 5'd2, 5'd4, 3'b100, 5'd5));           // xor
      prog.push_back(s_type(12'd4, 5'd5, 5'd0));
      prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd6));           // slt
      prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd7));           // sltu
      prog.push_back(s_type(12'd8, 5'd6, 5'd0));
      prog.push_back(s_type(12'd12, 5'd7, 5'd0));
      prog.push_back(r_type(7'h00, 5'd4, 5'd1, 3'b001, 5'd8));           // sll
      prog.push_back(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd9));           // sra
      prog.push_back(r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd10));          // srl
      prog.push_back(s_type(12'd16, 5'd8, 5'd0));
      prog.push_back(s_type(12'd20, 5'd9, 5'd0));
      prog.push_back(s_type(12'd24, 5'd10, 5'd0));
      prog.push_back(u_type(20'h12345, 5'd11, OPC_LUI));
      prog.push_back(i_type(12'h678, 5'd11, 3'b110, 5'd11, OPC_OP_IMM)); // ori
      prog.push_back(u_type(20'h00001, 5'd12, OPC_AUIPC));                // word 19
      prog.push_back(s_type(12'd28, 5'd11, 5'd0));
      prog.push_back(s_type(12'd32, 5'd12, 5'd0));
      prog.push_back(i_type(12'h0FF, 5'd11, 3'b111, 5'd13, OPC_OP_IMM)); // andi
      prog.push_back(i_type(12'h004, 5'd13, 3'b001, 5'd14, OPC_OP_IMM)); // slli
      prog.push_back(i_type(12'h401, 5'd2, 3'b101, 5'd15, OPC_OP_IMM));  // srai
      prog.push_back(r_type(7'h00, 5'd15, 5'd14, 3'b000, 5'd16));
      prog.push_back(s_type(12'd36, 5'd16, 5'd0));
      prog.push_back(i_type(12'd28, 5'd0, 3'b010, 5'd17, OPC_LOAD));     // Load then use
      prog.push_back(i_type(12'd1, 5'd17, 3'b000, 5'd18, OPC_OP_IMM));
      prog.push_back(s_type(12'd40, 5'd18, 5'd0));
      prog.push_back(i_type(12'd0, 5'd0, 3'b010, 5'd19, OPC_LOAD));
      prog.push_back(s_type(12'd44, 5'd19, 5'd0));                       // Store of loaded value
      prog.push_back(b_type(13'd12, 5'd1, 5'd1, 3'b000));                // beq taken
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));                        // Marker
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(b_type(13'd8, 5'd1, 5'd1, 3'b001));                 // bne not taken
      prog.push_back(b_type(13'd12, 5'd1, 5'd2, 3'b100));                // blt taken
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(b_type(13'd8, 5'd1, 5'd2, 3'b101));                 // bge not taken
      prog.push_back(s_type(12'd48, 5'd2, 5'd0));
      prog.push_back(j_type(21'd12, 5'd20));                             // word 41
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(s_type(12'd52, 5'd20, 5'd0));
      prog.push_back(u_type(20'h00000, 5'd21, OPC_AUIPC));                // word 45
      prog.push_back(i_type(12'd17, 5'd21, 3'b000, 5'd22, OPC_JALR));   // Odd offset
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(s_type(12'd60, 5'd1, 5'd0));
      prog.push_back(s_type(12'd56, 5'd22, 5'd0));
      prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd23, OPC_OP_IMM));
      prog.push_back(s_type(12'hFC, 5'd23, 5'd0));                       // Done store
      prog.push_back(j_type(21'd0, 5'd0));                               // Spin

      expect_store(32'h00, 32'd2);                    // 5 + -3
      expect_store(32'h04, 32'hFFFF_FFF5);            // 8 ^ -3
      expect_store(32'h08, 32'd1);                    // -3 < 5 signed
      expect_store(32'h0C, 32'd0);                    // Not below unsigned
      expect_store(32'h10, 32'h0000_0500);            // 5 << 8
      expect_store(32'h14, 32'hFFFF_FFFF);            // -3 >>> 2
      expect_store(32'h18, 32'h3FFF_FFFF);
      expect_store(32'h1C, 32'h1234_5678);
      expect_store(32'h20, PC_BASE + 32'd76 + 32'h1000);
      expect_store(32'h24, 32'h0000_077E);            // 0x780 + -2
      expect_store(32'h28, 32'h1234_5679);
      expect_store(32'h2C, 32'd2);
      expect_store(32'h30, 32'hFFFF_FFFD);
      expect_store(32'h34, PC_BASE + 32'd168);        // Link of the JAL at word 41
      expect_store(32'h38, PC_BASE + 32'd188);        // Link of the JALR at word 46
      expect_store(DONE_ADDR, 32'd1);
   endtask

   task automatic finish_run(bit timed_out);
      $display("store check errors: %0d, protocol assertion failures: %0d",
               errors, u_core.u_props.assert_fails);
      if (timed_out || errors != 0 || u_core.u_props.assert_fails != 0) begin
         $display("Verification failed");
      end else begin
         $display("Verification passed");
      end
      $finish;
   endtask

   initial begin
      load_program();
      for (int i = 0; i < 64; i++) begin
         dmem[i] = 32'hA5A5_0000 | word_t'(i);
      end
      wait (arst_n === 1'b1);
      while (!done && cycles < MAX_CYCLES) begin
         @(negedge clk);
         lfsr       = lfsr_step(lfsr);
         imem_ready = lfsr[0];
         lfsr       = lfsr_step(lfsr);
         dmem_ready = lfsr[0];
         imem_rdata = fetch_word(imem_addr);
         d_idx      = dmem_addr[7:2];
         dmem_rdata = dmem[d_idx];  // Read before any write this cycle
         if (dmem_valid && dmem_ready && dmem_we) begin
            check_store(dmem_addr, dmem_wdata);
            dmem[d_idx] = dmem_wdata;
         end
         cycles++;
      end
      if (!done) begin
         $display("timeout: no done store within %0d cycles", MAX_CYCLES);
      end
      assert (exp_addr.size() == 0) else begin
         errors++;
         $display("%0d expected stores never arrived", exp_addr.size());
      end
      finish_run(!done);
   end

endmodule

//--- verilog.f
rtl/core_pkg.sv
rtl/instruction_fetch_stage.sv
rtl/instruction_decode_stage.sv
rtl/instruction_execution_stage.sv
rtl/memory_stage.sv
rtl/core.sv
tests/tb_clock_gen.sv
tests/core_properties.sv
tests/tb_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_core -f verilog.f \
   --Mdir obj_dir -o sim_core
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

# Let assertion errors accumulate so the testbench can print its summary
./obj_dir/sim_core +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" sim.log; then
   exit 1
fi
exit 0
